/* lcd_display_top.f */
+incdir+common
common/lcd_pkg.sv
common/script_pkg.sv
script/font_rom.sv
script/display_script.sv
verilog/byte_fifo.sv
spi/lcd_spi_tx.sv
verilog/lcd_display_top.sv
verif/tb_lcd_display.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the lcd display testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

top=tb_lcd_display
log=sim.log

verilator --binary --timing --top-module "$top" -f lcd_display_top.f \
   --Mdir obj_dir -o "$top"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
fi

if grep -qx "Test completed successfully" "$log"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi

/* verif/tb_lcd_display.sv */
// lcd display testbench
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module tb_lcd_display;

   // ****************************************
   // stream layout
   // ****************************************
   localparam int CLEAR_FIRST = 5;                            // after five init commands
   localparam int DISP_ON     = CLEAR_FIRST + `LCD_CLEAR_BYTES;
   localparam int XY_FIRST    = DISP_ON + 1;                  // row 0 and col 6
   localparam int TEXT_FIRST  = XY_FIRST + 2;
   localparam int XY_DATE     = TEXT_FIRST + 8 * `GLYPH_COLS; // row 3 and col 7
   localparam int TEXT_DATE   = XY_DATE + 2;
   localparam int STREAM_LEN  = TEXT_DATE + 8 * `GLYPH_COLS;  // 610 bytes
   localparam int TIMEOUT_CYCLES = (STREAM_LEN * 10 + 20) * `LCD_CLK_DIV;

   logic clk = 1'b0;
   logic rst_n;
   logic lcd_clk;
   logic lcd_ce;
   logic lcd_dc;
   logic lcd_din;

   // receiver model state
   logic       lclk_prev = 1'b0;
   logic       ce_prev   = 1'b1;
   logic       din_prev  = 1'b0;
   logic       dc_prev   = 1'b0;
   logic       have_rise = 1'b0;
   logic [7:0] rx_shift  = 8'h00;
   int         cyc         = 0;
   int         last_rise   = 0;
   int         total_rises = 0;
   int         rx_rises    = 0;
   int         frames_started = 0;
   logic [8:0] rx_q [$];        // {dc, data} per frame

   // compare side
   logic [8:0] got_item;
   logic [8:0] exp_item;
   int         n_checked = 0;
   int         rises_before;    // snapshot for idle check

   lcd_display_top i_lcd_display_top (
      .clk     (clk),
      .rst_n   (rst_n),
      .lcd_clk (lcd_clk),
      .lcd_ce  (lcd_ce),
      .lcd_dc  (lcd_dc),
      .lcd_din (lcd_din)
   );

   always #10 clk = ~clk;   // 20 ns period

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // one font column with bit 0 as the top pixel
   function automatic logic [7:0] glyph_col(input logic [7:0] ch, input int col);
      logic [47:0] g;
      case (ch)
         "A":     g = 48'h00_7c_12_11_12_7c;
         "0":     g = 48'h00_3e_51_49_45_3e;
         "7":     g = 48'h00_01_71_09_05_03;
         "-":     g = 48'h00_08_08_08_08_08;
         "1":     g = 48'h00_00_42_7f_40_00;
         "_":     g = 48'h00_40_40_40_40_40;
         "V":     g = 48'h00_1f_20_40_20_1f;
         "2":     g = 48'h00_42_61_51_49_46;
         "6":     g = 48'h00_3c_4a_49_49_30;
         "3":     g = 48'h00_21_41_45_4b_31;
         default: g = 48'h0;
      endcase
      return g[47 - 8 * col -: 8];   // column 0 leftmost
   endfunction

   // expected nth byte as {dc, data}
   function automatic logic [8:0] expected_byte(input int n);
      logic [63:0] text;
      int          k;
      if (n < CLEAR_FIRST) begin
         case (n)
            0:       return {1'b0, 8'h21};
            1:       return {1'b0, 8'hc8};
            2:       return {1'b0, 8'h06};
            3:       return {1'b0, 8'h13};
            default: return {1'b0, 8'h20};
         endcase
      end else if (n < DISP_ON) begin
         return {1'b1, 8'h00};             // screen clear
      end else if (n == DISP_ON) begin
         return {1'b0, 8'h0c};
      end else if (n == XY_FIRST) begin
         return {1'b0, 8'h40 | 8'd0};      // set y to row 0
      end else if (n == XY_FIRST + 1) begin
         return {1'b0, 8'h80 | 8'd6};      // set x to col 6
      end else if (n < XY_DATE) begin
         text = "A07-1_V1";
         k    = n - TEXT_FIRST;
         return {1'b1, glyph_col(text[63 - 8 * (k / `GLYPH_COLS) -: 8], k % `GLYPH_COLS)};
      end else if (n == XY_DATE) begin
         return {1'b0, 8'h40 | 8'd3};
      end else if (n == XY_DATE + 1) begin
         return {1'b0, 8'h80 | 8'd7};
      end else begin
         text = "20161031";
         k    = n - TEXT_DATE;
         return {1'b1, glyph_col(text[63 - 8 * (k / `GLYPH_COLS) -: 8], k % `GLYPH_COLS)};
      end
   endfunction

   // ****************************************
   // bus receiver model sampled mid cycle
   // ****************************************
   always @(negedge clk) begin
      if (rst_n) begin
         cyc = cyc + 1;
         if (lcd_clk && !lclk_prev) begin      // lcd_clk rose this cycle
            if (have_rise)
               check_value("lcd_clk period", cyc - last_rise, `LCD_CLK_DIV);
            have_rise   = 1'b1;
            last_rise   = cyc;
            total_rises = total_rises + 1;
            if (!lcd_ce) begin
               check_value("lcd_din changed at rising edge", 32'(lcd_din), 32'(din_prev));
               check_value("lcd_dc changed at rising edge", 32'(lcd_dc), 32'(dc_prev));
               rx_shift = {rx_shift[6:0], lcd_din};   // msb first
               rx_rises = rx_rises + 1;
            end
         end
         if (!lcd_clk && lclk_prev && have_rise)
            check_value("lcd_clk high time", cyc - last_rise, `LCD_CLK_DIV - `LCD_CLK_LOW);
         if (!lcd_ce && ce_prev) begin         // frame start
            check_value("lcd_ce fall without lcd_clk fall", 32'(lclk_prev && !lcd_clk), 1);
            check_value("frame after end of stream", 32'(frames_started < STREAM_LEN), 1);
            frames_started = frames_started + 1;
            rx_rises       = 0;
         end
         if (lcd_ce && !ce_prev) begin         // frame end completes a byte
            check_value("rising edges per frame", rx_rises, 8);
            rx_q.push_back({lcd_dc, rx_shift});
         end
      end
      lclk_prev = lcd_clk;
      ce_prev   = lcd_ce;
      din_prev  = lcd_din;
      dc_prev   = lcd_dc;
   end

   // compare received bytes against the script rule
   always @(negedge clk) begin
      if (rx_q.size() != 0) begin
         got_item = rx_q.pop_front();
         exp_item = expected_byte(n_checked);
         check_value($sformatf("byte %0d dc", n_checked), 32'(got_item[8]), 32'(exp_item[8]));
         check_value($sformatf("byte %0d data", n_checked), 32'(got_item[7:0]),
                     32'(exp_item[7:0]));
         n_checked = n_checked + 1;
      end
   end

   // ****************************************
   // reset, run, end of test
   // ****************************************
   initial begin
      rst_n <= 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_value("lcd_ce after reset", 32'(lcd_ce), 1);
      check_value("lcd_clk after reset", 32'(lcd_clk), 0);
      check_value("lcd_din after reset", 32'(lcd_din), 0);
      check_value("lcd_dc after reset", 32'(lcd_dc), 0);
      while (n_checked < STREAM_LEN)
         @(posedge clk);
      rises_before = total_rises;
      repeat (2 * `LCD_CLK_DIV) @(posedge clk);   // two idle periods
      check_value("lcd_clk rises while idle", total_rises - rises_before, 2);
      check_value("lcd_ce high after stream", 32'(lcd_ce), 1);
      $display("Test completed successfully");
      $finish;
   end

   // watchdog allows ten lcd_clk periods per byte plus margin
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("watchdog expired: lcd transfers stalled after %0d of %0d bytes",
               n_checked, STREAM_LEN);
      $display("Test failed");
      $fatal(1, "timeout");
   end

endmodule

/* verilog/lcd_display_top.sv */
// lcd display top level
`timescale 1ns/1ps

module lcd_display_top (
   input  logic clk,
   input  logic rst_n,
   output logic lcd_clk,
   output logic lcd_ce,
   output logic lcd_dc,
   output logic lcd_din
);
   import lcd_pkg::*;

   logic      push;
   logic      full;
   logic      pop;
   logic      empty;
   lcd_byte_t push_item;   // script to fifo
   lcd_byte_t pop_item;    // fifo head to serializer

   display_script u_script (
      .clk       (clk),
      .rst_n     (rst_n),
      .full      (full),
      .push      (push),
      .push_item (push_item)
   );

   byte_fifo u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (push),
      .push_item (push_item),
      .pop       (pop),
      .pop_item  (pop_item),
      .full      (full),
      .empty     (empty)
   );

   lcd_spi_tx u_tx (
      .clk      (clk),
      .rst_n    (rst_n),
      .empty    (empty),
      .pop_item (pop_item),
      .pop      (pop),
      .lcd_clk  (lcd_clk),
      .lcd_ce   (lcd_ce),
      .lcd_dc   (lcd_dc),
      .lcd_din  (lcd_din)
   );

endmodule

/* spi/lcd_spi_tx.sv */
// lcd serial transmitter
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module lcd_spi_tx (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               empty,
   input  lcd_pkg::lcd_byte_t pop_item,
   output logic               pop,
   output logic               lcd_clk,
   output logic               lcd_ce,
   output logic               lcd_dc,
   output logic               lcd_din
);
   import lcd_pkg::*;

   localparam int CNT_W = $clog2(`LCD_CLK_DIV);

   logic [CNT_W-1:0] div_cnt;
   logic [CNT_W-1:0] div_nxt;
   logic             fall_tick;   // lcd_clk drops on this edge
   logic [6:0]       shift_q;     // bits still to send
   logic [3:0]       bit_cnt;     // bits already on the wire

   // ****************************************
   // clock divider
   // ****************************************
   assign fall_tick = (div_cnt == CNT_W'(`LCD_CLK_DIV - 1));
   assign div_nxt   = fall_tick ? '0 : div_cnt + 1'b1;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         div_cnt <= '0;
         lcd_clk <= 1'b0;
      end else begin
         div_cnt <= div_nxt;
         lcd_clk <= (div_nxt >= CNT_W'(`LCD_CLK_LOW));   // tracks div_cnt
      end
   end

   // ****************************************
   // serializer
   // ****************************************
   // start only from idle, ce high means idle
   assign pop = fall_tick && lcd_ce && !empty;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lcd_ce  <= 1'b1;
         lcd_dc  <= DC_CMD;
         lcd_din <= 1'b0;
         bit_cnt <= '0;
      end else if (fall_tick) begin
         if (pop) begin
            lcd_ce  <= 1'b0;
            lcd_dc  <= pop_item.dc;
            lcd_din <= pop_item.data[7];   // msb first
            bit_cnt <= 4'd1;
         end else if (!lcd_ce && bit_cnt == 4'd8) begin
            lcd_ce <= 1'b1;                // ninth fall ends frame
         end else if (!lcd_ce) begin
            lcd_din <= shift_q[6];
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         shift_q <= pop_item.data[6:0];
      end else if (fall_tick && !lcd_ce) begin
         shift_q <= {shift_q[5:0], 1'b0};
      end
   end

endmodule

/* verilog/byte_fifo.sv */
// bus byte fifo
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module byte_fifo (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               push,
   input  lcd_pkg::lcd_byte_t push_item,
   input  logic               pop,
   output lcd_pkg::lcd_byte_t pop_item,
   output logic               full,
   output logic               empty
);
   import lcd_pkg::*;

   localparam int AW = $clog2(`FIFO_DEPTH);

   lcd_byte_t       mem [`FIFO_DEPTH];
   logic [AW-1:0]   wr_ptr;
   logic [AW-1:0]   rd_ptr;
   logic [AW:0]     count;   // one extra bit for full
   logic            do_push;
   logic            do_pop;

   assign do_push  = push && !full;
   assign do_pop   = pop && !empty;
   assign full     = (count == (AW+1)'(`FIFO_DEPTH));
   assign empty    = (count == '0);
   assign pop_item = mem[rd_ptr];   // head, valid when not empty

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= push_item;
   end

   // pointers wrap on the power of two depth
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);   // both at once, no change
      end
   end

endmodule

/* script/display_script.sv */
// display script sequencer
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module display_script (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               full,
   output logic               push,
   output lcd_pkg::lcd_byte_t push_item
);
   import lcd_pkg::*;
   import script_pkg::*;

   localparam int IDX_W = $clog2(`SCRIPT_LEN);
   localparam int CNT_W = $clog2(`LCD_CLEAR_BYTES);

   logic [IDX_W-1:0] step_idx;   // current script step
   logic [CNT_W-1:0] byte_cnt;   // byte within step
   logic             run;        // armed one cycle after reset
   logic             last_byte;  // final byte of this step
   script_step_t     step;
   glyph_t           glyph;

   function automatic script_step_t byte_step(step_kind_t kind, logic [7:0] code);
      script_step_t s;
      s.kind                 = kind;
      s.payload.as_byte.pad  = 2'b00;
      s.payload.as_byte.code = code;
      return s;
   endfunction

   function automatic script_step_t xy_step(logic [2:0] row, logic [6:0] col);
      script_step_t s;
      s.kind               = STEP_XY;
      s.payload.as_pos.row = row;
      s.payload.as_pos.col = col;
      return s;
   endfunction

   // ****************************************
   // script rom
   // ****************************************
   always_comb begin
      case (step_idx)
         5'd0:  step = byte_step(STEP_CMD, CMD_FUNC_EXT);    // panel init
         5'd1:  step = byte_step(STEP_CMD, CMD_VOP);
         5'd2:  step = byte_step(STEP_CMD, CMD_TEMP);
         5'd3:  step = byte_step(STEP_CMD, CMD_BIAS);
         5'd4:  step = byte_step(STEP_CMD, CMD_FUNC_BASIC);
         5'd5:  step = byte_step(STEP_CLEAR, 8'h00);
         5'd6:  step = byte_step(STEP_CMD, CMD_DISP_NORM);
         5'd7:  step = xy_step(3'd0, 7'd6);                 // first line
         5'd8:  step = byte_step(STEP_CHAR, "A");
         5'd9:  step = byte_step(STEP_CHAR, "0");
         5'd10: step = byte_step(STEP_CHAR, "7");
         5'd11: step = byte_step(STEP_CHAR, "-");
         5'd12: step = byte_step(STEP_CHAR, "1");
         5'd13: step = byte_step(STEP_CHAR, "_");
         5'd14: step = byte_step(STEP_CHAR, "V");
         5'd15: step = byte_step(STEP_CHAR, "1");
         5'd16: step = xy_step(3'd3, 7'd7);                 // date line
         5'd17: step = byte_step(STEP_CHAR, "2");
         5'd18: step = byte_step(STEP_CHAR, "0");
         5'd19: step = byte_step(STEP_CHAR, "1");
         5'd20: step = byte_step(STEP_CHAR, "6");
         5'd21: step = byte_step(STEP_CHAR, "1");
         5'd22: step = byte_step(STEP_CHAR, "0");
         5'd23: step = byte_step(STEP_CHAR, "3");
         5'd24: step = byte_step(STEP_CHAR, "1");
         default: step = byte_step(STEP_END, 8'h00);        // park here
      endcase
   end

   font_rom u_font (
      .code  (step.payload.as_byte.code),
      .glyph (glyph)
   );

   // ****************************************
   // step expansion
   // ****************************************
   always_comb begin
      push_item.dc   = DC_DATA;
      push_item.data = 8'h00;   // clear and end
      last_byte      = 1'b1;
      case (step.kind)
         STEP_CMD: begin
            push_item.dc   = DC_CMD;
            push_item.data = step.payload.as_byte.code;
         end
         STEP_CLEAR: last_byte = (byte_cnt == CNT_W'(`LCD_CLEAR_BYTES - 1));
         STEP_XY: begin
            push_item.dc   = DC_CMD;
            push_item.data = byte_cnt[0] ? (CMD_SET_X | {1'b0, step.payload.as_pos.col})
                                         : (CMD_SET_Y | {5'd0, step.payload.as_pos.row});
            last_byte      = byte_cnt[0];  // y first, then x
         end
         STEP_CHAR: begin
            push_item.data = glyph[byte_cnt[2:0]];
            last_byte      = (byte_cnt == CNT_W'(`GLYPH_COLS - 1));
         end
         default: ;
      endcase
   end

   assign push = run && (step.kind != STEP_END) && !full;   // stall on full

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         run      <= 1'b0;
         step_idx <= '0;
         byte_cnt <= '0;
      end else begin
         run <= 1'b1;
         if (push) begin
            if (last_byte) begin
               byte_cnt <= '0;
               step_idx <= step_idx + 1'b1;
            end else begin
               byte_cnt <= byte_cnt + 1'b1;
            end
         end
      end
   end

endmodule

/* script/font_rom.sv */
// 6x8 ascii glyph table
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module font_rom (
   input  logic [7:0]      code,
   output lcd_pkg::glyph_t glyph
);

   // columns left to right, bit 0 is the top pixel
   always_comb begin
      case (code)
         8'd32:  glyph = {8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00}; // space
         8'd33:  glyph = {8'h00, 8'h00, 8'h00, 8'h2f, 8'h00, 8'h00}; // !
         8'd34:  glyph = {8'h00, 8'h00, 8'h07, 8'h00, 8'h07, 8'h00};
         8'd35:  glyph = {8'h00, 8'h14, 8'h7f, 8'h14, 8'h7f, 8'h14}; // #
         8'd36:  glyph = {8'h00, 8'h24, 8'h2a, 8'h7f, 8'h2a, 8'h12};
         8'd37:  glyph = {8'h00, 8'h62, 8'h64, 8'h08, 8'h13, 8'h23};
         8'd38:  glyph = {8'h00, 8'h36, 8'h49, 8'h55, 8'h22, 8'h50};
         8'd39:  glyph = {8'h00, 8'h00, 8'h05, 8'h03, 8'h00, 8'h00};
         8'd40:  glyph = {8'h00, 8'h00, 8'h1c, 8'h22, 8'h41, 8'h00}; // (
         8'd41:  glyph = {8'h00, 8'h00, 8'h41, 8'h22, 8'h1c, 8'h00}; // )
         8'd42:  glyph = {8'h00, 8'h14, 8'h08, 8'h3e, 8'h08, 8'h14};
         8'd43:  glyph = {8'h00, 8'h08, 8'h08, 8'h3e, 8'h08, 8'h08};
         8'd44:  glyph = {8'h00, 8'h00, 8'h00, 8'ha0, 8'h60, 8'h00};
         8'd45:  glyph = {8'h00, 8'h08, 8'h08, 8'h08, 8'h08, 8'h08}; // -
         8'd46:  glyph = {8'h00, 8'h00, 8'h60, 8'h60, 8'h00, 8'h00};
         8'd47:  glyph = {8'h00, 8'h20, 8'h10, 8'h08, 8'h04, 8'h02};
         // digits
         8'd48:  glyph = {8'h00, 8'h3e, 8'h51, 8'h49, 8'h45, 8'h3e};
         8'd49:  glyph = {8'h00, 8'h00, 8'h42, 8'h7f, 8'h40, 8'h00};
         8'd50:  glyph = {8'h00, 8'h42, 8'h61, 8'h51, 8'h49, 8'h46};
         8'd51:  glyph = {8'h00, 8'h21, 8'h41, 8'h45, 8'h4b, 8'h31};
         8'd52:  glyph = {8'h00, 8'h18, 8'h14, 8'h12, 8'h7f, 8'h10};
         8'd53:  glyph = {8'h00, 8'h27, 8'h45, 8'h45, 8'h45, 8'h39};
         8'd54:  glyph = {8'h00, 8'h3c, 8'h4a, 8'h49, 8'h49, 8'h30};
         8'd55:  glyph = {8'h00, 8'h01, 8'h71, 8'h09, 8'h05, 8'h03};
         8'd56:  glyph = {8'h00, 8'h36, 8'h49, 8'h49, 8'h49, 8'h36};
         8'd57:  glyph = {8'h00, 8'h06, 8'h49, 8'h49, 8'h29, 8'h1e};
         8'd58:  glyph = {8'h00, 8'h00, 8'h36, 8'h36, 8'h00, 8'h00}; // :
         8'd59:  glyph = {8'h00, 8'h00, 8'h56, 8'h36, 8'h00, 8'h00};
         8'd60:  glyph = {8'h00, 8'h08, 8'h14, 8'h22, 8'h41, 8'h00};
         8'd61:  glyph = {8'h00, 8'h14, 8'h14, 8'h14, 8'h14, 8'h14};
         8'd62:  glyph = {8'h00, 8'h00, 8'h41, 8'h22, 8'h14, 8'h08};
         8'd63:  glyph = {8'h00, 8'h02, 8'h01, 8'h51, 8'h09, 8'h06};
         8'd64:  glyph = {8'h00, 8'h32, 8'h49, 8'h59, 8'h51, 8'h3e}; // @
         // upper case
         8'd65:  glyph = {8'h00, 8'h7c, 8'h12, 8'h11, 8'h12, 8'h7c};
         8'd66:  glyph = {8'h00, 8'h7f, 8'h49, 8'h49, 8'h49, 8'h36};
         8'd67:  glyph = {8'h00, 8'h3e, 8'h41, 8'h41, 8'h41, 8'h22};
         8'd68:  glyph = {8'h00, 8'h7f, 8'h41, 8'h41, 8'h22, 8'h1c};
         8'd69:  glyph = {8'h00, 8'h7f, 8'h49, 8'h49, 8'h49, 8'h41};
         8'd70:  glyph = {8'h00, 8'h7f, 8'h09, 8'h09, 8'h09, 8'h01};
         8'd71:  glyph = {8'h00, 8'h3e, 8'h41, 8'h49, 8'h49, 8'h7a};
         8'd72:  glyph = {8'h00, 8'h7f, 8'h08, 8'h08, 8'h08, 8'h7f};
         8'd73:  glyph = {8'h00, 8'h00, 8'h41, 8'h7f, 8'h41, 8'h00};
         8'd74:  glyph = {8'h00, 8'h20, 8'h40, 8'h41, 8'h3f, 8'h01};
         8'd75:  glyph = {8'h00, 8'h7f, 8'h08, 8'h14, 8'h22, 8'h41};
         8'd76:  glyph = {8'h00, 8'h7f, 8'h40, 8'h40, 8'h40, 8'h40};
         8'd77:  glyph = {8'h00, 8'h7f, 8'h02, 8'h0c, 8'h02, 8'h7f};
         8'd78:  glyph = {8'h00, 8'h7f, 8'h04, 8'h08, 8'h10, 8'h7f};
         8'd79:  glyph = {8'h00, 8'h3e, 8'h41, 8'h41, 8'h41, 8'h3e};
         8'd80:  glyph = {8'h00, 8'h7f, 8'h09, 8'h09, 8'h09, 8'h06};
         8'd81:  glyph = {8'h00, 8'h3e, 8'h41, 8'h51, 8'h21, 8'h5e};
         8'd82:  glyph = {8'h00, 8'h7f, 8'h09, 8'h19, 8'h29, 8'h46};
         8'd83:  glyph = {8'h00, 8'h46, 8'h49, 8'h49, 8'h49, 8'h31};
         8'd84:  glyph = {8'h00, 8'h01, 8'h01, 8'h7f, 8'h01, 8'h01};
         8'd85:  glyph = {8'h00, 8'h3f, 8'h40, 8'h40, 8'h40, 8'h3f};
         8'd86:  glyph = {8'h00, 8'h1f, 8'h20, 8'h40, 8'h20, 8'h1f};
         8'd87:  glyph = {8'h00, 8'h3f, 8'h40, 8'h38, 8'h40, 8'h3f};
         8'd88:  glyph = {8'h00, 8'h63, 8'h14, 8'h08, 8'h14, 8'h63};
         8'd89:  glyph = {8'h00, 8'h07, 8'h08, 8'h70, 8'h08, 8'h07};
         8'd90:  glyph = {8'h00, 8'h61, 8'h51, 8'h49, 8'h45, 8'h43};
         8'd91:  glyph = {8'h00, 8'h00, 8'h7f, 8'h41, 8'h41, 8'h00}; // [, backslash left blank
         8'd93:  glyph = {8'h00, 8'h00, 8'h41, 8'h41, 8'h7f, 8'h00}; // ]
         8'd94:  glyph = {8'h00, 8'h04, 8'h02, 8'h01, 8'h02, 8'h04};
         8'd95:  glyph = {8'h00, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40}; // _
         8'd96:  glyph = {8'h00, 8'h00, 8'h01, 8'h02, 8'h04, 8'h00};
         // lower case
         8'd97:  glyph = {8'h00, 8'h20, 8'h54, 8'h54, 8'h54, 8'h78};
         8'd98:  glyph = {8'h00, 8'h7f, 8'h48, 8'h44, 8'h44, 8'h38};
         8'd99:  glyph = {8'h00, 8'h38, 8'h44, 8'h44, 8'h44, 8'h20};
         8'd100: glyph = {8'h00, 8'h38, 8'h44, 8'h44, 8'h48, 8'h7f};
         8'd101: glyph = {8'h00, 8'h38, 8'h54, 8'h54, 8'h54, 8'h18};
         8'd102: glyph = {8'h00, 8'h08, 8'h7e, 8'h09, 8'h01, 8'h02};
         8'd103: glyph = {8'h00, 8'h18, 8'ha4, 8'ha4, 8'ha4, 8'h7c}; // descender
         8'd104: glyph = {8'h00, 8'h7f, 8'h08, 8'h04, 8'h04, 8'h78};
         8'd105: glyph = {8'h00, 8'h00, 8'h44, 8'h7d, 8'h40, 8'h00};
         8'd106: glyph = {8'h00, 8'h40, 8'h80, 8'h84, 8'h7d, 8'h00};
         8'd107: glyph = {8'h00, 8'h7f, 8'h10, 8'h28, 8'h44, 8'h00};
         8'd108: glyph = {8'h00, 8'h00, 8'h41, 8'h7f, 8'h40, 8'h00};
         8'd109: glyph = {8'h00, 8'h7c, 8'h04, 8'h18, 8'h04, 8'h78};
         8'd110: glyph = {8'h00, 8'h7c, 8'h08, 8'h04, 8'h04, 8'h78};
         8'd111: glyph = {8'h00, 8'h38, 8'h44, 8'h44, 8'h44, 8'h38};
         8'd112: glyph = {8'h00, 8'hfc, 8'h24, 8'h24, 8'h24, 8'h18};
         8'd113: glyph = {8'h00, 8'h18, 8'h24, 8'h24, 8'h18, 8'hfc};
         8'd114: glyph = {8'h00, 8'h7c, 8'h08, 8'h04, 8'h04, 8'h08};
         8'd115: glyph = {8'h00, 8'h48, 8'h54, 8'h54, 8'h54, 8'h20};
         8'd116: glyph = {8'h00, 8'h04, 8'h3f, 8'h44, 8'h40, 8'h20};
         8'd117: glyph = {8'h00, 8'h3c, 8'h40, 8'h40, 8'h20, 8'h7c};
         8'd118: glyph = {8'h00, 8'h1c, 8'h20, 8'h40, 8'h20, 8'h1c};
         8'd119: glyph = {8'h00, 8'h3c, 8'h40, 8'h30, 8'h40, 8'h3c};
         8'd120: glyph = {8'h00, 8'h44, 8'h28, 8'h10, 8'h28, 8'h44};
         8'd121: glyph = {8'h00, 8'h1c, 8'ha0, 8'ha0, 8'ha0, 8'h7c};
         8'd122: glyph = {8'h00, 8'h44, 8'h64, 8'h54, 8'h4c, 8'h44}; // z
         default: glyph = {`GLYPH_COLS{8'h00}};                      // blank
      endcase
   end

endmodule

/* common/script_pkg.sv */
// display script step types
package script_pkg;

   // what a step expands to
   typedef enum logic [2:0] {
      STEP_CMD,   // one command byte
      STEP_CLEAR, // zero fill of the whole panel
      STEP_XY,    // y then x address command
      STEP_CHAR,  // glyph columns
      STEP_END    // stream done
   } step_kind_t;

   // byte view, command or character code
   typedef struct packed {
      logic [1:0] pad;
      logic [7:0] code;
   } step_byte_t;

   // pos view for address steps
   typedef struct packed {
      logic [2:0] row;  // bank 0..5
      logic [6:0] col;  // column 0..83
   } step_pos_t;

   typedef union packed {
      step_byte_t as_byte;
      step_pos_t  as_pos;
   } step_payload_u;

   typedef struct packed {
      step_kind_t    kind;
      step_payload_u payload;
   } script_step_t;

endpackage

/* common/lcd_pkg.sv */
// lcd panel bus types
package lcd_pkg;

`include "lcd_cfg.svh"

   // dc pin levels
   localparam logic DC_CMD  = 1'b0;
   localparam logic DC_DATA = 1'b1;

   // one bus transfer, unit of the byte fifo
   typedef struct packed {
      logic       dc;   // 0 command, 1 data
      logic [7:0] data;
   } lcd_byte_t;

   // column 0 sits in the top byte
   typedef logic [0:`GLYPH_COLS-1][7:0] glyph_t;

   // ****************************************
   // controller commands
   // ****************************************
   localparam logic [7:0] CMD_FUNC_EXT   = 8'h21; // extended set, horizontal
   localparam logic [7:0] CMD_VOP        = 8'hc8; // contrast
   localparam logic [7:0] CMD_TEMP       = 8'h06; // temp coefficient
   localparam logic [7:0] CMD_BIAS       = 8'h13; // bias 1:48
   localparam logic [7:0] CMD_FUNC_BASIC = 8'h20; // back to basic set
   localparam logic [7:0] CMD_DISP_NORM  = 8'h0c; // normal mode
   localparam logic [7:0] CMD_SET_Y      = 8'h40; // or'ed with bank row
   localparam logic [7:0] CMD_SET_X      = 8'h80; // or'ed with column

endpackage

/* common/lcd_cfg.svh */
// lcd panel build constants
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// ****************************************
// serial clock divider
// ****************************************
`define LCD_CLK_DIV 149     // lcd_clk period in clk cycles
`define LCD_CLK_LOW 74      // counts with lcd_clk low

// ****************************************
// display script
// ****************************************
`define LCD_CLEAR_BYTES 504 // 84 columns x 6 banks
`define GLYPH_COLS 6        // column bytes per character
`define SCRIPT_LEN 26       // steps incl. the end marker

// byte buffer, power of two
`define FIFO_DEPTH 4

`endif
